// File: cam_pkg.sv
// Key and data widths are fixed in this package, only the entry count is a module parameter
package cam_pkg;

   // Width of the lookup key in bits
   localparam int key_width = 16;

   // Width of the stored data word in bits
   localparam int data_width = 32;

   // Entry count used by the top level when none is given
   // It must stay a power of two and at least 2
   localparam int default_els = 8;

   // Lookup key, compared against every valid entry
   typedef logic [key_width-1:0] key_t;

   // Data word stored alongside each key
   typedef logic [data_width-1:0] data_t;

   // Write request as it arrives on the write port
   // The key selects overwrite or allocation, the data is stored either way
   typedef struct packed {
      key_t  key;
      data_t data;
   } cam_wr_t;

   // Lookup response, returned one cycle after the lookup strobe
   // On a miss the hit flag is low and the data field is all zeros
   typedef struct packed {
      logic  hit;
      data_t data;
   } cam_rsp_t;

   // The write request is 48 bits wide
   // The response is 33 bits wide, hit flag on top

endpackage

// File: cam_tag_array.sv
// Keys written must stay unique across valid entries, so each match vector is at most one-hot
`timescale 1ns/1ps

module cam_tag_array #(
   parameter int els_p = 8
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic [els_p-1:0]   we_i,
   input  cam_pkg::key_t      w_key_i,
   input  cam_pkg::key_t      r_key_i,
   output logic [els_p-1:0]   r_match_o,
   output logic [els_p-1:0]   w_match_o,
   output logic [els_p-1:0]   empty_o
);

   // Valid bits start cleared after reset
   logic [els_p-1:0] valid_r;

   // Stored keys are only meaningful where the valid bit is set
   cam_pkg::key_t keys_r [els_p];

   // A written entry becomes valid at the same edge that stores its key
   // There is no invalidation, so valid bits only ever go from 0 to 1
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         valid_r <= '0;
      end
      else
      begin
         valid_r <= valid_r | we_i;
      end
   end

   // Each enabled entry takes the write key and stale keys stay masked by their valid bits
   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < els_p; i++)
      begin
         if (we_i[i])
         begin
            keys_r[i] <= w_key_i;
         end
      end
   end

   // Both keys are compared against every entry in parallel
   // The compare uses current state, so a write at this edge is not yet seen
   always_comb
   begin
      for (int i = 0; i < els_p; i++)
      begin
         r_match_o[i] = valid_r[i] && (keys_r[i] == r_key_i);
         w_match_o[i] = valid_r[i] && (keys_r[i] == w_key_i);
      end
   end

   // Empty entries feed the allocation priority in the replacement block
   assign empty_o = ~valid_r;

endmodule

// File: cam_data_array.sv
// Read is combinational from the one-hot select and gives zero when no select bit is set
`timescale 1ns/1ps

module cam_data_array #(
   parameter int els_p = 8
) (
   input  logic               clk_i,
   input  logic [els_p-1:0]   we_i,
   input  cam_pkg::data_t     w_data_i,
   input  logic [els_p-1:0]   r_sel_i,
   output cam_pkg::data_t     r_data_o
);

   // Data storage, one word per entry
   cam_pkg::data_t mem_r [els_p];

   // The write enable is one-hot, so at most one word changes per edge
   always_ff @(posedge clk_i)
   begin
      for (int i = 0; i < els_p; i++)
      begin
         if (we_i[i])
         begin
            mem_r[i] <= w_data_i;
         end
      end
   end

   // AND-OR read mux
   // Each word is masked by its select bit and the results are ORed together
   // A miss has no select bit set, which gives the zero data of a miss response
   always_comb
   begin
      r_data_o = '0;
      for (int i = 0; i < els_p; i++)
      begin
         r_data_o = r_data_o | (mem_r[i] & {cam_pkg::data_width{r_sel_i[i]}});
      end
   end

endmodule

// File: cam_replacement.sv
// Tree pseudo-LRU for els_p a power of two and at least 2, touch vector assumed one-hot or zero
`timescale 1ns/1ps

module cam_replacement #(
   parameter int els_p = 8
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic [els_p-1:0]   touch_v_i,
   input  logic               alloc_v_i,
   input  logic [els_p-1:0]   empty_i,
   output logic [els_p-1:0]   alloc_v_o
);

   // Tree depth and number of internal nodes
   localparam int lg_els_lp = $clog2(els_p);
   localparam int nodes_lp  = els_p - 1;

   // Node k has children 2k+1 and 2k+2, leaves are entries left to right
   // A node bit of 0 says the less recently used side is the left one
   logic [nodes_lp-1:0]  lru_r;
   logic [nodes_lp-1:0]  touch_n;
   logic [nodes_lp-1:0]  lru_n;

   logic [lg_els_lp-1:0] tree_way;
   logic [lg_els_lp-1:0] empty_way;
   logic                 empty_found;
   logic [lg_els_lp-1:0] victim_way;
   logic [lg_els_lp-1:0] touch_way;
   logic                 touch_v;

   // Follows the node bits from the root down to a leaf
   function automatic logic [lg_els_lp-1:0] tree_victim(
      input logic [nodes_lp-1:0] bits
   );
      int unsigned node;
      node = 0;
      for (int lvl = 0; lvl < lg_els_lp; lvl++)
      begin
         // Step to the child on the less recently used side
         node = 2 * node + 1 + int'(bits[node]);
      end
      // Leaf nodes start right after the internal nodes
      return lg_els_lp'(node - nodes_lp);
   endfunction

   // Marks an entry as most recently used
   // Every node on its path is pointed away from it, other nodes keep their bits
   function automatic logic [nodes_lp-1:0] mark_used(
      input logic [nodes_lp-1:0]  cur,
      input logic [lg_els_lp-1:0] way
   );
      logic [nodes_lp-1:0] nxt;
      int unsigned         node;
      int unsigned         parent;
      nxt  = cur;
      node = int'(way) + nodes_lp;
      for (int lvl = 0; lvl < lg_els_lp; lvl++)
      begin
         parent = (node - 1) / 2;
         // An odd node is a left child, so the parent now points right
         nxt[parent] = node[0];
         node = parent;
      end
      return nxt;
   endfunction

   assign tree_way = tree_victim(lru_r);

   // Lowest-numbered empty entry, found by letting lower indices win
   always_comb
   begin
      empty_way = '0;
      for (int i = els_p - 1; i >= 0; i--)
      begin
         if (empty_i[i])
         begin
            empty_way = lg_els_lp'(i);
         end
      end
   end

   assign empty_found = |empty_i;

   // Empty entries take priority over the tree victim
   assign victim_way = empty_found ? empty_way : tree_way;

   // One-hot form of the chosen entry
   assign alloc_v_o = els_p'(1) << victim_way;

   // Index of the touched entry, an OR of indices is enough for a one-hot input
   always_comb
   begin
      touch_way = '0;
      for (int i = 0; i < els_p; i++)
      begin
         if (touch_v_i[i])
         begin
            touch_way = touch_way | lg_els_lp'(i);
         end
      end
   end

   assign touch_v = |touch_v_i;

   // First stage applies the lookup touch
   assign touch_n = touch_v ? mark_used(lru_r, touch_way) : lru_r;

   // Second stage applies the allocation on top, so it wins on shared nodes
   assign lru_n = alloc_v_i ? mark_used(touch_n, victim_way) : touch_n;

   // Without a touch or allocation lru_n equals lru_r, so no enable is needed
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         lru_r <= '0;
      end
      else
      begin
         lru_r <= lru_n;
      end
   end

endmodule

// File: cam_ctrl.sv
// No back-pressure, the response is valid for one cycle and must be taken when it appears
`timescale 1ns/1ps

module cam_ctrl #(
   parameter int els_p = 8
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               w_v_i,
   input  cam_pkg::cam_wr_t   w_i,
   input  logic               r_v_i,
   input  logic [els_p-1:0]   r_match_i,
   input  logic [els_p-1:0]   w_match_i,
   input  logic [els_p-1:0]   victim_i,
   input  cam_pkg::data_t     r_data_i,
   output logic [els_p-1:0]   we_o,
   output cam_pkg::cam_wr_t   w_o,
   output logic [els_p-1:0]   touch_v_o,
   output logic               alloc_v_o,
   output logic               r_v_o,
   output cam_pkg::cam_rsp_t  r_rsp_o
);

   // Write key already stored somewhere in the array
   logic w_hit;

   // Registered response valid and payload
   logic              r_v_r;
   cam_pkg::cam_rsp_t rsp_r;
   cam_pkg::cam_rsp_t rsp_n;

   assign w_hit = |w_match_i;

   // A write hit overwrites the matching entry in place
   // A write miss goes to the victim chosen by the replacement block
   assign we_o = w_v_i ? (w_hit ? w_match_i : victim_i) : '0;

   // Write key and data go to the tag and data arrays with the enable
   assign w_o = w_i;

   // Only allocations move the tree, write hits leave it alone
   assign alloc_v_o = w_v_i & ~w_hit;

   // A lookup hit touches its entry, a miss has an all-zero match vector
   assign touch_v_o = r_v_i ? r_match_i : '0;

   // Read data is already zero on a miss because of the AND-OR read
   assign rsp_n.hit  = |r_match_i;
   assign rsp_n.data = r_data_i;

   // One cycle of latency from lookup strobe to response
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         r_v_r <= 1'b0;
         rsp_r <= '0;
      end
      else
      begin
         r_v_r <= r_v_i;
         // The payload holds its last value between lookups
         if (r_v_i)
         begin
            rsp_r <= rsp_n;
         end
      end
   end

   assign r_v_o   = r_v_r;
   assign r_rsp_o = rsp_r;

endmodule

// File: cam_top.sv
// els_p must be a power of two and at least 2, and a lookup sees state from before a same-edge write
`timescale 1ns/1ps

module cam_top #(
   parameter int els_p = cam_pkg::default_els
) (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  logic               w_v_i,
   input  cam_pkg::cam_wr_t   w_i,
   input  logic               r_v_i,
   input  cam_pkg::key_t      r_key_i,
   output logic               r_v_o,
   output cam_pkg::cam_rsp_t  r_rsp_o
);

   // Match and empty vectors from the tag array
   logic [els_p-1:0] r_match;
   logic [els_p-1:0] w_match;
   logic [els_p-1:0] empty;

   // Write enables, lookup touch and allocation from the controller
   logic [els_p-1:0] we;
   logic [els_p-1:0] touch_v;
   logic             alloc_v;
   cam_pkg::cam_wr_t ctrl_w;

   // Victim entry from the replacement block and read data from the data array
   logic [els_p-1:0] victim;
   cam_pkg::data_t   r_data;

   cam_ctrl #(
      .els_p (els_p)
   ) ctrl0 (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .w_v_i     (w_v_i),
      .w_i       (w_i),
      .r_v_i     (r_v_i),
      .r_match_i (r_match),
      .w_match_i (w_match),
      .victim_i  (victim),
      .r_data_i  (r_data),
      .we_o      (we),
      .w_o       (ctrl_w),
      .touch_v_o (touch_v),
      .alloc_v_o (alloc_v),
      .r_v_o     (r_v_o),
      .r_rsp_o   (r_rsp_o)
   );

   cam_tag_array #(
      .els_p (els_p)
   ) tags0 (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .we_i      (we),
      .w_key_i   (ctrl_w.key),
      .r_key_i   (r_key_i),
      .r_match_o (r_match),
      .w_match_o (w_match),
      .empty_o   (empty)
   );

   // The read select is the lookup match vector itself
   cam_data_array #(
      .els_p (els_p)
   ) data0 (
      .clk_i    (clk_i),
      .we_i     (we),
      .w_data_i (ctrl_w.data),
      .r_sel_i  (r_match),
      .r_data_o (r_data)
   );

   cam_replacement #(
      .els_p (els_p)
   ) repl0 (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .touch_v_i (touch_v),
      .alloc_v_i (alloc_v),
      .empty_i   (empty),
      .alloc_v_o (victim)
   );

endmodule

// File: tb_cam.sv
// Reference model is built for els_p of 8 and checks responses with concurrent assertions per edge
`timescale 1ns/1ps

module tb_cam;

   localparam int els_lp    = 8;
   localparam int lg_els_lp = 3;
   localparam int pool_lp   = 24;

   // DUT ports
   logic              clk_i = 1'b0;
   logic              rst_n_i;
   logic              w_v_i;
   cam_pkg::cam_wr_t  w_i;
   logic              r_v_i;
   cam_pkg::key_t     r_key_i;
   logic              r_v_o;
   cam_pkg::cam_rsp_t r_rsp_o;

   // Reference model of keys, data, valid bits and the pseudo-LRU tree
   cam_pkg::key_t     m_key [els_lp];
   cam_pkg::data_t    m_data [els_lp];
   logic [els_lp-1:0] m_valid = '0;
   logic [els_lp-2:0] m_tree = '0;

   // Expected responses in lookup order, and the one due on the response port now
   cam_pkg::cam_rsp_t exp_q [$];
   logic              exp_v = 1'b0;
   cam_pkg::cam_rsp_t exp_rsp = '0;
   int                issued = 0;
   int                seen = 0;

   // Keys written by the directed tests, and the key pool of the random run
   cam_pkg::key_t     known [$];
   cam_pkg::key_t     pool [pool_lp];

   cam_top #(
      .els_p (els_lp)
   ) dut0 (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .w_v_i   (w_v_i),
      .w_i     (w_i),
      .r_v_i   (r_v_i),
      .r_key_i (r_key_i),
      .r_v_o   (r_v_o),
      .r_rsp_o (r_rsp_o)
   );

   always #5 clk_i = ~clk_i;

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("TESTS FAILED");
      $fatal(1, "Response mismatch");
   endtask

   task automatic report_failure(input string what);
      $display("Error at %0t ns: %s", $time, what);
      $display("TESTS FAILED");
      $fatal(1, "Testbench error");
   endtask

   // Index of a valid entry holding the key, or -1 when the key is not stored
   function automatic int find_entry(input cam_pkg::key_t key);
      for (int i = 0; i < els_lp; i++)
      begin
         if (m_valid[i] && m_key[i] == key)
         begin
            return i;
         end
      end
      return -1;
   endfunction

   // Lowest empty entry wins, otherwise walk the tree from the root toward the LRU side
   function automatic int pick_victim();
      int node;
      node = 0;
      for (int i = 0; i < els_lp; i++)
      begin
         if (!m_valid[i])
         begin
            return i;
         end
      end
      for (int lvl = 0; lvl < lg_els_lp; lvl++)
      begin
         node = m_tree[node] ? 2 * node + 2 : 2 * node + 1;
      end
      return node - (els_lp - 1);
   endfunction

   // Walks from the root using the entry bits, MSB first, and points each node away
   function automatic void point_away(input int entry);
      int node;
      int side;
      node = 0;
      for (int lvl = lg_els_lp - 1; lvl >= 0; lvl--)
      begin
         side = (entry >> lvl) & 1;
         // Entry on the left makes the right side least recently used
         m_tree[node] = (side == 0);
         node = 2 * node + 1 + side;
      end
   endfunction

   // One operation cycle of the model, the lookup sees state from before the write
   task automatic model_step(input logic do_w, input cam_pkg::cam_wr_t wr, input logic do_r,
                             input cam_pkg::key_t rkey, output cam_pkg::cam_rsp_t rsp);
      int r_idx;
      int w_idx;
      int victim;
      r_idx  = find_entry(rkey);
      w_idx  = find_entry(wr.key);
      victim = pick_victim();
      rsp    = '0;
      if (r_idx >= 0)
      begin
         rsp.hit  = 1'b1;
         rsp.data = m_data[r_idx];
      end
      // Lookup touch goes first so an allocation wins on shared nodes
      if (do_r && r_idx >= 0)
      begin
         point_away(r_idx);
      end
      if (do_w)
      begin
         // A write hit keeps the tree as it is
         if (w_idx < 0)
         begin
            point_away(victim);
            w_idx = victim;
         end
         m_key[w_idx]   = wr.key;
         m_data[w_idx]  = wr.data;
         m_valid[w_idx] = 1'b1;
      end
   endtask

   // Drives one cycle of strobes and records the expected lookup response
   task automatic issue(input logic do_w, input cam_pkg::key_t wkey, input cam_pkg::data_t wdata,
                        input logic do_r, input cam_pkg::key_t rkey);
      cam_pkg::cam_wr_t  wr;
      cam_pkg::cam_rsp_t rsp;
      wr.key  = wkey;
      wr.data = wdata;
      @(posedge clk_i);
      w_v_i   <= do_w;
      w_i     <= wr;
      r_v_i   <= do_r;
      r_key_i <= rkey;
      model_step(do_w, wr, do_r, rkey, rsp);
      if (do_r)
      begin
         exp_q.push_back(rsp);
         issued++;
      end
   endtask

   // Drops the strobes, then waits until every lookup has produced its response
   task automatic wait_responses();
      int cycles;
      cycles = 0;
      @(posedge clk_i);
      w_v_i <= 1'b0;
      r_v_i <= 1'b0;
      while (seen != issued)
      begin
         if (cycles >= 16)
         begin
            report_failure("timeout while waiting for lookup responses");
         end
         else
         begin
            @(negedge clk_i);
            cycles++;
         end
      end
   endtask

   task automatic lookup_known();
      foreach (known[i])
      begin
         issue(1'b0, '0, '0, 1'b1, known[i]);
      end
      wait_responses();
   endtask

   // Moves the expected response forward with the same one-cycle latency as the DUT
   always @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         exp_v   <= 1'b0;
         exp_rsp <= '0;
      end
      else
      begin
         exp_v <= r_v_i;
         if (r_v_i)
         begin
            if (exp_q.size() == 0)
               report_failure("a lookup was taken with no expected response queued");
            else
               exp_rsp <= exp_q.pop_front();
         end
         if (r_v_o)
         begin
            seen++;
         end
      end
   end

   valid_check: assert property (@(posedge clk_i) disable iff (!rst_n_i) r_v_o == exp_v)
      else report_mismatch("r_v_o", 64'($sampled(r_v_o)), 64'($sampled(exp_v)));

   rsp_check: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                               r_v_o |-> r_rsp_o == exp_rsp)
      else report_mismatch("r_rsp_o", 64'($sampled(r_rsp_o)), 64'($sampled(exp_rsp)));

   // Right after reset the response port is idle and cleared
   reset_check: assert property (@(posedge clk_i)
                                 (rst_n_i && !$past(rst_n_i)) |-> (!r_v_o && r_rsp_o == '0))
      else report_mismatch("{r_v_o, r_rsp_o}",
                           64'({$sampled(r_v_o), $sampled(r_rsp_o)}), 64'(0));

   initial
   begin
      logic do_w;
      logic do_r;
      rst_n_i = 1'b0;
      w_v_i   = 1'b0;
      w_i     = '0;
      r_v_i   = 1'b0;
      r_key_i = '0;
      void'($urandom(32'h6233_9270));
      for (int i = 0; i < pool_lp; i++)
      begin
         pool[i] = 16'h2000 + 16'(i) * 16'h0105;
      end
      repeat (3) @(posedge clk_i);
      rst_n_i <= 1'b1;

      // On an empty CAM idle cycles give no response and lookups miss with zero data
      repeat (4) @(posedge clk_i);
      for (int i = 0; i < 4; i++)
      begin
         issue(1'b0, '0, '0, 1'b1, pool[$urandom % pool_lp]);
      end
      wait_responses();

      // Eight distinct keys fill every empty entry in order
      for (int i = 0; i < els_lp; i++)
      begin
         known.push_back(16'h1000 + 16'(i));
         issue(1'b1, known[i], $urandom, 1'b0, '0);
      end
      lookup_known();

      // Overwrite in place leaves the tree alone, so a new key still takes the old victim
      issue(1'b1, known[3], $urandom, 1'b0, '0);
      known.push_back(16'h9000);
      issue(1'b1, 16'h9000, $urandom, 1'b0, '0);
      lookup_known();

      // Touch some entries, then a new key evicts the tree victim
      issue(1'b0, '0, '0, 1'b1, known[8]);
      issue(1'b0, '0, '0, 1'b1, known[5]);
      issue(1'b0, '0, '0, 1'b1, known[2]);
      issue(1'b0, '0, '0, 1'b1, known[7]);
      known.push_back(16'ha000);
      issue(1'b1, 16'ha000, $urandom, 1'b0, '0);
      lookup_known();

      // Lookup and write of the same key in one cycle see the old data
      issue(1'b1, known[5], 32'h5a5a_0005, 1'b1, known[5]);
      issue(1'b0, '0, '0, 1'b1, known[5]);
      wait_responses();

      // A lookup hit on the other half and an allocation in one cycle set the root
      // The next eviction then shows which of the two won
      known.push_back(16'hb000);
      issue(1'b1, 16'hb000, $urandom, 1'b1, known[6]);
      known.push_back(16'hc000);
      issue(1'b1, 16'hc000, $urandom, 1'b0, '0);
      lookup_known();

      // Random traffic over a pool three times the entry count
      for (int cyc = 0; cyc < 2000; cyc++)
      begin
         do_w = ($urandom % 2) == 0;
         do_r = ($urandom % 4) != 0;
         issue(do_w, pool[$urandom % pool_lp], $urandom, do_r, pool[$urandom % pool_lp]);
      end
      wait_responses();

      if (exp_q.size() == 0 && seen == issued)
      begin
         $display("TESTS PASSED");
         $finish;
      end
      else
      begin
         $display("Lookups issued %0d but responses seen %0d", issued, seen);
         $display("TESTS FAILED");
         $fatal(1, "Response count mismatch");
      end
   end

endmodule

// File: sim.f
cam_pkg.sv
cam_tag_array.sv
cam_data_array.sv
cam_replacement.sv
cam_ctrl.sv
cam_top.sv
tb_cam.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module tb_cam -o sim_cam || exit 1
out=$(./obj_dir/sim_cam 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "TESTS PASSED" && exit 0 || exit 1
